//--- verilog/monbus_pkg.sv
// Packets are 64 bits with the type in bits 63 to 60 and type codes 6 through 15 reserved
`default_nettype none

package monbus_pkg;

        // ==============================
        // Packet geometry
        // ==============================

        // Width of one monitor bus event packet
        localparam int MONBUS_WIDTH = 64;

        // Event class field at the top of the packet
        localparam int PKT_TYPE_MSB = 63;
        localparam int PKT_TYPE_LSB = 60;

        // Saturating drop counter size
        localparam int DROP_COUNT_WIDTH = 16;

        // ==============================
        // Encodings
        // ==============================

        // Event classes carried in the type field
        // Codes above PKT_DEBUG are reserved
        typedef enum logic [3:0] {
                PKT_ERROR      = 4'h0,
                PKT_COMPLETION = 4'h1,
                PKT_TIMEOUT    = 4'h2,
                PKT_THRESHOLD  = 4'h3,
                PKT_PERF       = 4'h4,
                PKT_DEBUG      = 4'h5
        } monbus_pkt_type_e;

        // Round-robin arbiter FSM
        typedef enum logic {
                ARB_IDLE    = 1'b0,
                ARB_GRANTED = 1'b1
        } arb_state_e;

endpackage

`default_nettype wire

//--- verilog/monbus_skid_buffer.sv
// SKID_DEPTH must be 2, 4 or 8 and reset is synchronous and active while axi_aresetn is high
`timescale 1ns/100ps
`default_nettype none

module monbus_skid_buffer #(
        parameter int SKID_DEPTH = 2
) (
        input  logic                                axi_aclk,
        input  logic                                axi_aresetn,
        // Write side
        input  logic                                wr_valid,
        output logic                                wr_ready,
        input  logic [monbus_pkg::MONBUS_WIDTH-1:0] wr_data,
        // Read side
        output logic                                rd_valid,
        input  logic                                rd_ready,
        output logic [monbus_pkg::MONBUS_WIDTH-1:0] rd_data
);

        // Power-of-two depth so the pointers wrap on their own
        localparam int PTR_WIDTH = $clog2(SKID_DEPTH);
        localparam int CNT_WIDTH = $clog2(SKID_DEPTH + 1);

        logic [monbus_pkg::MONBUS_WIDTH-1:0] mem [SKID_DEPTH];
        logic [PTR_WIDTH-1:0]                wr_ptr;
        logic [PTR_WIDTH-1:0]                rd_ptr;
        logic [CNT_WIDTH-1:0]                count;
        logic                                active;
        logic                                full;
        logic                                do_write;
        logic                                do_read;

        // ==============================
        // Handshake
        // ==============================

        assign full = (count == CNT_WIDTH'(SKID_DEPTH));

        // Held low for the first cycle out of reset
        // A full buffer still takes a word when it drains one
        assign wr_ready = active && (!full || rd_ready);

        // Output comes from stored state only
        assign rd_valid = (count != '0);
        assign rd_data  = mem[rd_ptr];

        assign do_write = wr_valid && wr_ready;
        assign do_read  = rd_valid && rd_ready;

        // ==============================
        // Storage and pointers
        // ==============================

        always_ff @(posedge axi_aclk) begin
                if (do_write) begin
                        mem[wr_ptr] <= wr_data;
                end
        end

        always_ff @(posedge axi_aclk) begin
                if (axi_aresetn) begin
                        active <= 1'b0;
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        active <= 1'b1;
                        if (do_write) begin
                                wr_ptr <= wr_ptr + 1'b1;
                        end
                        if (do_read) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                        // Occupancy unchanged on simultaneous read and write
                        case ({do_write, do_read})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

endmodule

`default_nettype wire

//--- verilog/monbus_rr_arbiter.sv
// Grant is registered and held until grant_ack, reset is synchronous and active while high
`timescale 1ns/100ps
`default_nettype none

module monbus_rr_arbiter #(
        parameter int CLIENTS = 4
) (
        input  logic                       axi_aclk,
        input  logic                       axi_aresetn,
        input  logic                       block_arb,
        input  logic [CLIENTS-1:0]         request,
        input  logic                       grant_ack,
        output logic                       grant_valid,
        output logic [CLIENTS-1:0]         grant,
        output logic [$clog2(CLIENTS)-1:0] grant_id
);

        localparam int ID_WIDTH = $clog2(CLIENTS);

        monbus_pkg::arb_state_e state;

        // Most recent winner, start point of the next search
        logic [ID_WIDTH-1:0] last_id;

        // Search result
        logic [ID_WIDTH-1:0] next_id;
        logic                next_found;

        // ==============================
        // Round-robin search
        // ==============================

        // Scan from the client after the last winner
        // Wraps around and ends on the last winner itself
        always_comb begin
                int idx;
                next_id    = last_id;
                next_found = 1'b0;
                for (int off = 1; off <= CLIENTS; off++) begin
                        idx = (int'(last_id) + off) % CLIENTS;
                        // First hit wins
                        if (!next_found && request[idx]) begin
                                next_id    = ID_WIDTH'(idx);
                                next_found = 1'b1;
                        end
                end
        end

        // ==============================
        // Grant FSM
        // ==============================

        always_ff @(posedge axi_aclk) begin
                if (axi_aresetn) begin
                        state   <= monbus_pkg::ARB_IDLE;
                        grant   <= '0;
                        // Client 0 gets the first grant
                        last_id <= ID_WIDTH'(CLIENTS - 1);
                end else begin
                        case (state)
                                monbus_pkg::ARB_IDLE: begin
                                        // No new grant while blocked
                                        if (next_found && !block_arb) begin
                                                state   <= monbus_pkg::ARB_GRANTED;
                                                grant   <= CLIENTS'(1) << next_id;
                                                last_id <= next_id;
                                        end
                                end
                                monbus_pkg::ARB_GRANTED: begin
                                        // Held grant finishes even under block_arb
                                        if (grant_ack) begin
                                                state <= monbus_pkg::ARB_IDLE;
                                                grant <= '0;
                                        end
                                end
                                default: begin
                                        state <= monbus_pkg::ARB_IDLE;
                                        grant <= '0;
                                end
                        endcase
                end
        end

        // Status straight from registers
        assign grant_valid = (state == monbus_pkg::ARB_GRANTED);

        // Keeps naming the last winner once the grant drops
        assign grant_id = last_id;

endmodule

`default_nettype wire

//--- verilog/monbus_arbiter.sv
// One packet in flight per grant so throughput is one packet per two cycles at most
`timescale 1ns/100ps
`default_nettype none

module monbus_arbiter #(
        parameter int CLIENTS    = 4,
        parameter int SKID_DEPTH = 2
) (
        input  logic                                        axi_aclk,
        input  logic                                        axi_aresetn,
        input  logic                                        block_arb,
        // Client side, one bit or one packet slice per client
        input  logic [CLIENTS-1:0]                          client_valid,
        output logic [CLIENTS-1:0]                          client_ready,
        input  logic [CLIENTS*monbus_pkg::MONBUS_WIDTH-1:0] client_packet,
        // Merged stream toward the filter
        output logic                                        arb_valid,
        input  logic                                        arb_ready,
        output logic [monbus_pkg::MONBUS_WIDTH-1:0]         arb_packet,
        // Status
        output logic                                        grant_valid,
        output logic [$clog2(CLIENTS)-1:0]                  grant_id
);

        localparam int PKT_W = monbus_pkg::MONBUS_WIDTH;

        // Buffered client streams
        logic [CLIENTS-1:0] buf_valid;
        logic [CLIENTS-1:0] buf_ready;
        logic [PKT_W-1:0]   buf_packet [CLIENTS];

        // Arbiter handshake
        logic [CLIENTS-1:0] grant;
        logic               grant_ack;

        // ==============================
        // Input skid buffers
        // ==============================

        for (genvar i = 0; i < CLIENTS; i++) begin : gen_input_skid
                monbus_skid_buffer #(
                        .SKID_DEPTH (SKID_DEPTH)
                ) u_input_skid (
                        .axi_aclk    (axi_aclk),
                        .axi_aresetn (axi_aresetn),
                        .wr_valid    (client_valid[i]),
                        .wr_ready    (client_ready[i]),
                        .wr_data     (client_packet[i*PKT_W +: PKT_W]),
                        .rd_valid    (buf_valid[i]),
                        .rd_ready    (buf_ready[i]),
                        .rd_data     (buf_packet[i])
                );
        end

        // ==============================
        // Arbitration
        // ==============================

        // A buffered packet is the request
        monbus_rr_arbiter #(
                .CLIENTS (CLIENTS)
        ) u_rr_arbiter (
                .axi_aclk    (axi_aclk),
                .axi_aresetn (axi_aresetn),
                .block_arb   (block_arb),
                .request     (buf_valid),
                .grant_ack   (grant_ack),
                .grant_valid (grant_valid),
                .grant       (grant),
                .grant_id    (grant_id)
        );

        // Only the granted buffer sees downstream ready
        assign buf_ready = grant & {CLIENTS{arb_ready}};

        // ==============================
        // Packet mux
        // ==============================

        // Granted buffer stays valid until its packet leaves
        assign arb_valid = grant_valid && buf_valid[grant_id];

        // Zero when nothing is granted
        always_comb begin
                arb_packet = '0;
                if (grant_valid) begin
                        arb_packet = buf_packet[grant_id];
                end
        end

        // Transfer of the granted packet releases the grant
        assign grant_ack = arb_valid && arb_ready;

endmodule

`default_nettype wire

//--- verilog/monbus_filter.sv
// Combinational pass or drop with drop_mask indexed by type code and a counter that saturates
`timescale 1ns/100ps
`default_nettype none

module monbus_filter (
        input  logic                                    axi_aclk,
        input  logic                                    axi_aresetn,
        // One bit per type code, set to drop
        input  logic [15:0]                             drop_mask,
        // From the arbiter
        input  logic                                    arb_valid,
        output logic                                    arb_ready,
        input  logic [monbus_pkg::MONBUS_WIDTH-1:0]     arb_packet,
        // Toward the output buffer
        output logic                                    filt_valid,
        input  logic                                    filt_ready,
        output logic [monbus_pkg::MONBUS_WIDTH-1:0]     filt_packet,
        // Status
        output logic [monbus_pkg::DROP_COUNT_WIDTH-1:0] drop_count
);

        monbus_pkg::monbus_pkt_type_e pkt_type;
        logic                         masked;
        logic                         drop;

        // ==============================
        // Type decode
        // ==============================

        // Event class from the top nibble
        assign pkt_type = monbus_pkg::monbus_pkt_type_e'(
                arb_packet[monbus_pkg::PKT_TYPE_MSB:monbus_pkg::PKT_TYPE_LSB]);

        // Reserved codes follow the mask too
        assign masked = drop_mask[pkt_type];

        // ==============================
        // Forward or consume
        // ==============================

        // Masked packets are taken at once, others wait on downstream
        assign arb_ready = masked || filt_ready;

        // Forward path
        assign filt_valid  = arb_valid && !masked;
        assign filt_packet = arb_packet;

        // Drop happens on the same edge it is accepted
        assign drop = arb_valid && masked;

        // ==============================
        // Drop counter
        // ==============================

        always_ff @(posedge axi_aclk) begin
                if (axi_aresetn) begin
                        drop_count <= '0;
                end else if (drop && (drop_count != '1)) begin
                        // Stops at all ones
                        drop_count <= drop_count + 1'b1;
                end
        end

endmodule

`default_nettype wire

//--- verilog/monbus_hub.sv
// CLIENTS must be 2 or more, SKID_DEPTH 2, 4 or 8 and reset is active while axi_aresetn is high
`timescale 1ns/100ps
`default_nettype none

module monbus_hub #(
        parameter int CLIENTS    = 4,
        parameter int SKID_DEPTH = 2
) (
        input  logic                                        axi_aclk,
        input  logic                                        axi_aresetn,
        // Clients
        input  logic [CLIENTS-1:0]                          client_valid,
        output logic [CLIENTS-1:0]                          client_ready,
        input  logic [CLIENTS*monbus_pkg::MONBUS_WIDTH-1:0] client_packet,
        // Merged output stream
        output logic                                        monbus_valid,
        input  logic                                        monbus_ready,
        output logic [monbus_pkg::MONBUS_WIDTH-1:0]         monbus_packet,
        // Control
        input  logic                                        block_arb,
        input  logic [15:0]                                 drop_mask,
        // Status
        output logic                                        grant_valid,
        output logic [$clog2(CLIENTS)-1:0]                  grant_id,
        output logic [monbus_pkg::DROP_COUNT_WIDTH-1:0]     drop_count
);

        // Arbiter to filter
        logic                                arb_valid;
        logic                                arb_ready;
        logic [monbus_pkg::MONBUS_WIDTH-1:0] arb_packet;

        // Filter to output buffer
        logic                                filt_valid;
        logic                                filt_ready;
        logic [monbus_pkg::MONBUS_WIDTH-1:0] filt_packet;

        // ==============================
        // Input buffers and arbitration
        // ==============================

        monbus_arbiter #(
                .CLIENTS    (CLIENTS),
                .SKID_DEPTH (SKID_DEPTH)
        ) u_arbiter (
                .axi_aclk      (axi_aclk),
                .axi_aresetn   (axi_aresetn),
                .block_arb     (block_arb),
                .client_valid  (client_valid),
                .client_ready  (client_ready),
                .client_packet (client_packet),
                .arb_valid     (arb_valid),
                .arb_ready     (arb_ready),
                .arb_packet    (arb_packet),
                .grant_valid   (grant_valid),
                .grant_id      (grant_id)
        );

        // ==============================
        // Type filter
        // ==============================

        monbus_filter u_filter (
                .axi_aclk    (axi_aclk),
                .axi_aresetn (axi_aresetn),
                .drop_mask   (drop_mask),
                .arb_valid   (arb_valid),
                .arb_ready   (arb_ready),
                .arb_packet  (arb_packet),
                .filt_valid  (filt_valid),
                .filt_ready  (filt_ready),
                .filt_packet (filt_packet),
                .drop_count  (drop_count)
        );

        // ==============================
        // Output buffer
        // ==============================

        // Registers the output and absorbs monbus_ready stalls
        monbus_skid_buffer #(
                .SKID_DEPTH (SKID_DEPTH)
        ) u_output_skid (
                .axi_aclk    (axi_aclk),
                .axi_aresetn (axi_aresetn),
                .wr_valid    (filt_valid),
                .wr_ready    (filt_ready),
                .wr_data     (filt_packet),
                .rd_valid    (monbus_valid),
                .rd_ready    (monbus_ready),
                .rd_data     (monbus_packet)
        );

endmodule

`default_nettype wire

//--- test/monbus_hub_props.sv
// Bound into monbus_hub and reads its arb_valid net, reset is active while axi_aresetn is high
`timescale 1ns/100ps
`default_nettype none

module monbus_hub_props (
        input logic                                    axi_aclk,
        input logic                                    axi_aresetn,
        input logic                                    block_arb,
        input logic                                    grant_valid,
        input logic                                    arb_valid,
        input logic                                    monbus_valid,
        input logic                                    monbus_ready,
        input logic [monbus_pkg::MONBUS_WIDTH-1:0]     monbus_packet,
        input logic [monbus_pkg::DROP_COUNT_WIDTH-1:0] drop_count
);

        // ==============================
        // Arbitration
        // ==============================

        // Granted client must be offering a packet
        a_grant_requested: assert property (@(posedge axi_aclk) disable iff (axi_aresetn)
                grant_valid |-> arb_valid)
                else $error("grant_valid high while the granted client offers no packet");

        // No new grant starts while blocked
        a_block_no_grant: assert property (@(posedge axi_aclk) disable iff (axi_aresetn)
                (block_arb && !grant_valid) |=> !grant_valid)
                else $error("grant_valid rose while block_arb was high");

        // ==============================
        // Output stream
        // ==============================

        // Offered packet held until taken
        a_out_stable: assert property (@(posedge axi_aclk) disable iff (axi_aresetn)
                (monbus_valid && !monbus_ready) |=> (monbus_valid && $stable(monbus_packet)))
                else $error("monbus_valid or monbus_packet changed while monbus_ready was low");

        // First cycle out of reset
        a_reset_values: assert property (@(posedge axi_aclk)
                $fell(axi_aresetn) |-> (!monbus_valid && !grant_valid && (drop_count == '0)))
                else $error("outputs not at their reset values after reset");

endmodule

`default_nettype wire

//--- test/monbus_hub_tb.sv
// Fixed at CLIENTS 4 and SKID_DEPTH 2, and samples arbiter requests through a path into dut0
`timescale 1ns/100ps
`default_nettype none

module monbus_hub_tb;

        localparam int CLIENTS         = 4;
        localparam int SKID_DEPTH      = 2;
        localparam int W               = monbus_pkg::MONBUS_WIDTH;
        localparam int ID_W            = $clog2(CLIENTS);
        localparam int DCW             = monbus_pkg::DROP_COUNT_WIDTH;
        // Packets per client in each phase
        localparam int PKTS            = 8;
        localparam int PHASES          = 4;
        localparam int WATCHDOG_CYCLES = PKTS * PHASES * CLIENTS * 20;

        // Drop masks, reserved codes 6 and 7 show up in the stimulus too
        localparam logic [15:0] MASK_B = 16'(1 << monbus_pkg::PKT_TIMEOUT)
                                       | 16'(1 << monbus_pkg::PKT_PERF) | 16'h0080;
        localparam logic [15:0] MASK_C = 16'(1 << monbus_pkg::PKT_ERROR)
                                       | 16'(1 << monbus_pkg::PKT_DEBUG) | 16'h0040;
        localparam logic [15:0] MASK_D = 16'(1 << monbus_pkg::PKT_COMPLETION)
                                       | 16'(1 << monbus_pkg::PKT_THRESHOLD);

        logic               axi_aclk;
        logic               axi_aresetn;
        logic [CLIENTS-1:0] client_valid;
        logic [CLIENTS-1:0] client_ready;
        logic [CLIENTS*W-1:0] client_packet;
        logic               monbus_valid;
        logic               monbus_ready;
        logic [W-1:0]       monbus_packet;
        logic               block_arb;
        logic [15:0]        drop_mask;
        logic               grant_valid;
        logic [ID_W-1:0]    grant_id;
        logic [DCW-1:0]     drop_count;

        // Stimulus state
        integer             seed;
        int                 target;
        int                 sent [CLIENTS];
        logic [15:0]        seq_no [CLIENTS];
        logic               gaps_on;
        int                 ready_lvl;
        int                 exp_drops;

        // Expected unmasked packets per client
        logic [W-1:0]       exp_q [CLIENTS][$];

        // Round-robin tracking
        logic [CLIENTS-1:0] reqs;
        logic               have_prev;
        logic [ID_W-1:0]    prev_id;
        logic               rr_pending;
        logic [ID_W-1:0]    rr_expect;

        monbus_hub #(
                .CLIENTS    (CLIENTS),
                .SKID_DEPTH (SKID_DEPTH)
        ) dut0 (
                .axi_aclk      (axi_aclk),
                .axi_aresetn   (axi_aresetn),
                .client_valid  (client_valid),
                .client_ready  (client_ready),
                .client_packet (client_packet),
                .monbus_valid  (monbus_valid),
                .monbus_ready  (monbus_ready),
                .monbus_packet (monbus_packet),
                .block_arb     (block_arb),
                .drop_mask     (drop_mask),
                .grant_valid   (grant_valid),
                .grant_id      (grant_id),
                .drop_count    (drop_count)
        );

        bind monbus_hub monbus_hub_props u_props (
                .axi_aclk      (axi_aclk),
                .axi_aresetn   (axi_aresetn),
                .block_arb     (block_arb),
                .grant_valid   (grant_valid),
                .arb_valid     (arb_valid),
                .monbus_valid  (monbus_valid),
                .monbus_ready  (monbus_ready),
                .monbus_packet (monbus_packet),
                .drop_count    (drop_count)
        );

        // Buffered client packets are the arbiter requests
        assign reqs = dut0.u_arbiter.buf_valid;

        always #5 axi_aclk = ~axi_aclk;

        // ==============================
        // Helpers
        // ==============================

        task automatic abort_run(input string msg);
                $display("%s", msg);
                $display("test failed");
                $fatal(1);
        endtask

        // Type in [63:60], client tag in [59:56], sequence in [55:40]
        function automatic logic [W-1:0] build_packet(input int client);
                logic [31:0] rnd;
                logic [3:0]  ptype;
                rnd = $random(seed);
                ptype = {1'b0, rnd[2:0]};
                rnd = $random(seed);
                seq_no[client] = seq_no[client] + 16'd1;
                return {ptype, 4'(client), seq_no[client], 8'h00, rnd};
        endfunction

        // Walk forward from the previous winner until a request is found
        function automatic logic [ID_W-1:0] next_winner(input logic [ID_W-1:0] last,
                                                        input logic [CLIENTS-1:0] req);
                int idx;
                idx = (int'(last) + 1) % CLIENTS;
                while (!req[idx]) begin
                        idx = (idx + 1) % CLIENTS;
                end
                return ID_W'(idx);
        endfunction

        function automatic logic hub_idle();
                logic idle;
                idle = !grant_valid && !monbus_valid && (client_valid == '0) && (reqs == '0);
                for (int i = 0; i < CLIENTS; i++) begin
                        idle = idle && (sent[i] == target) && (exp_q[i].size() == 0);
                end
                return idle;
        endfunction

        // ==============================
        // Input drivers
        // ==============================

        always @(posedge axi_aclk) begin : drive_inputs
                logic [31:0] rnd;
                logic [W-1:0] pkt;
                logic [3:0]  ptype;
                logic        accepted;
                logic        want;
                rnd = $random(seed);
                // Output back-pressure, always ready at level 128
                monbus_ready <= (int'(rnd[6:0]) < ready_lvl);
                if (!axi_aresetn) begin
                        for (int i = 0; i < CLIENTS; i++) begin
                                accepted = client_valid[i] && client_ready[i];
                                if (accepted) begin
                                        pkt = client_packet[i*W +: W];
                                        ptype = pkt[monbus_pkg::PKT_TYPE_MSB:
                                                    monbus_pkg::PKT_TYPE_LSB];
                                        // Masked types only bump the drop total
                                        if (drop_mask[ptype])
                                                exp_drops++;
                                        else
                                                exp_q[i].push_back(pkt);
                                        sent[i]++;
                                end
                                // Valid held until transfer
                                if (!client_valid[i] || accepted) begin
                                        rnd = $random(seed);
                                        want = !gaps_on || (rnd[1:0] != 2'b00);
                                        if ((sent[i] < target) && want) begin
                                                client_packet[i*W +: W] <= build_packet(i);
                                                client_valid[i]         <= 1'b1;
                                        end else begin
                                                client_valid[i] <= 1'b0;
                                        end
                                end
                        end
                end
        end

        // ==============================
        // Output and grant checks
        // ==============================

        always @(posedge axi_aclk) begin : check_outputs
                logic [W-1:0] exp_pkt;
                int           tag;
                if (axi_aresetn) begin
                        have_prev  = 1'b0;
                        rr_pending = 1'b0;
                end else begin
                        if (monbus_valid && monbus_ready) begin
                                tag = int'(monbus_packet[59:56]);
                                assert (!drop_mask[monbus_packet[63:60]])
                                        else abort_run(
                                                "A packet of a masked type reached the output");
                                assert (tag < CLIENTS)
                                        else abort_run(
                                                "Output packet carries an unknown client tag");
                                assert (exp_q[tag].size() > 0)
                                        else abort_run(
                                                "Output packet arrived with nothing expected");
                                exp_pkt = exp_q[tag].pop_front();
                                assert (monbus_packet == exp_pkt)
                                        else abort_run($sformatf(
                                                "Mismatch monbus_packet: expected %h, got %h",
                                                exp_pkt, monbus_packet));
                        end
                        // Grant one edge after an idle edge with requests
                        if (rr_pending) begin
                                assert (grant_valid)
                                        else abort_run("Arbiter did not grant a waiting request");
                                assert (grant_id == rr_expect)
                                        else abort_run($sformatf(
                                                "Mismatch grant_id: expected %h, got %h",
                                                rr_expect, grant_id));
                        end
                        rr_pending = have_prev && !grant_valid && !block_arb && (reqs != '0);
                        if (rr_pending)
                                rr_expect = next_winner(prev_id, reqs);
                        if (grant_valid) begin
                                prev_id   = grant_id;
                                have_prev = 1'b1;
                        end
                end
        end

        // ==============================
        // Phases
        // ==============================

        task automatic run_phase(input logic [15:0] mask, input logic gaps, input int lvl,
                                 input int block_cycles);
                @(posedge axi_aclk);
                // Mask only changes while the hub is empty
                drop_mask <= mask;
                gaps_on   <= gaps;
                ready_lvl <= lvl;
                block_arb <= (block_cycles > 0);
                target    <= target + PKTS;
                repeat (block_cycles) @(posedge axi_aclk);
                block_arb <= 1'b0;
                do @(negedge axi_aclk); while (!hub_idle());
                assert (drop_count == DCW'(exp_drops))
                        else abort_run($sformatf("Mismatch drop_count: expected %h, got %h",
                                DCW'(exp_drops), drop_count));
        endtask

        initial begin : watchdog
                repeat (WATCHDOG_CYCLES) @(posedge axi_aclk);
                abort_run($sformatf("Timeout after %0d cycles with packets still pending",
                        WATCHDOG_CYCLES));
        end

        initial begin : main_sequence
                axi_aclk      = 1'b0;
                axi_aresetn   = 1'b1;
                client_valid  = '0;
                client_packet = '0;
                monbus_ready  = 1'b0;
                block_arb     = 1'b0;
                drop_mask     = '0;
                seed          = 32'h05b4_e857;
                target        = 0;
                gaps_on       = 1'b0;
                ready_lvl     = 128;
                exp_drops     = 0;
                for (int i = 0; i < CLIENTS; i++) begin
                        sent[i]   = 0;
                        seq_no[i] = '0;
                end
                repeat (2) @(posedge axi_aclk);
                axi_aresetn <= 1'b0;
                // Saturated clients, nothing masked, output always ready
                run_phase(16'h0000, 1'b0, 128, 0);
                // Gaps and light back-pressure
                run_phase(MASK_B, 1'b1, 80, 0);
                // Arbitration blocked while the input buffers fill
                run_phase(MASK_C, 1'b1, 100, 12);
                // Heavy back-pressure
                run_phase(MASK_D, 1'b1, 24, 0);
                $display("test passed");
                $finish;
        end

endmodule

`default_nettype wire

//--- monbus_hub.f
verilog/monbus_pkg.sv
verilog/monbus_skid_buffer.sv
verilog/monbus_rr_arbiter.sv
verilog/monbus_arbiter.sv
verilog/monbus_filter.sv
verilog/monbus_hub.sv
test/monbus_hub_props.sv
test/monbus_hub_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := monbus_hub_tb
FILELIST  := monbus_hub.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SOURCES   := $(wildcard verilog/*.sv) $(wildcard test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
